/* common/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Address and data path widths.
`define ADDR_W 64
`define DATA_W 64
`define MASK_W 8

// Four sets. Index is addr[4:3], tag is addr[63:5].
`define SET_BITS 2

// Backing memory, indexed by addr[10:3].
`define MEM_WORDS 256
`define MEM_LATENCY 3

// Bound on any single wait in the testbench.
`define TIMEOUT_CYCLES 200

`endif

/* common/cachePkg.sv */
`default_nettype none
`include "cache_defines.svh"

package cachePkg;

    // One core request. The mask is only meaningful for stores.
    typedef struct packed {
        logic               write;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
        logic [`MASK_W-1:0] mask;
    } cpuReq_t;

    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic               hit;
    } cpuResp_t;

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } memCmd_t;

    typedef struct packed {
        memCmd_t            cmd;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
        logic [`MASK_W-1:0] mask;
    } memReq_t;

    typedef enum logic [1:0] {
        IDLE,
        MEM_WAIT,
        RESPOND
    } ctrlState_t;

    // Byte-lane merge used by both the cache and the memory.
    function automatic logic [`DATA_W-1:0] mergeBytes(
        input logic [`DATA_W-1:0] oldWord,
        input logic [`DATA_W-1:0] newWord,
        input logic [`MASK_W-1:0] mask
    );
        logic [`DATA_W-1:0] merged;
        merged = oldWord;
        for (int b = 0; b < `MASK_W; b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

/* cache/cacheArray.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cacheArray (
    input  wire                 clk,
    input  wire                 rst,
    input  wire [`ADDR_W-1:0]   lookupAddr,
    input  wire                 fillValid,
    input  wire [`ADDR_W-1:0]   fillAddr,
    input  wire [`DATA_W-1:0]   fillData,
    input  wire                 storeValid,
    input  wire [`ADDR_W-1:0]   storeAddr,
    input  wire                 storeWay,
    input  wire [`DATA_W-1:0]   storeData,
    input  wire [`MASK_W-1:0]   storeMask,
    output logic                hit,
    output logic                hitWay,
    output logic [`DATA_W-1:0]  hitData
);
    import cachePkg::*;

    localparam int NUM_SETS = 1 << `SET_BITS;
    localparam int TAG_W    = `ADDR_W - `SET_BITS - 3;

    logic [`DATA_W-1:0]  dataMem [2][NUM_SETS];
    logic [TAG_W-1:0]    tagMem [2][NUM_SETS];
    logic [NUM_SETS-1:0] validMem [2];
    logic [NUM_SETS-1:0] replWay;    // Next way to fill, per set.

    logic [`SET_BITS-1:0] lookupSet;
    logic [TAG_W-1:0]     lookupTag;
    logic [`SET_BITS-1:0] fillSet;
    logic [TAG_W-1:0]     fillTag;
    logic                 fillWay;
    logic [`SET_BITS-1:0] storeSet;
    logic [1:0]           wayHit;

    assign lookupSet = lookupAddr[`SET_BITS+2:3];
    assign lookupTag = lookupAddr[`ADDR_W-1:`SET_BITS+3];
    assign fillSet   = fillAddr[`SET_BITS+2:3];
    assign fillTag   = fillAddr[`ADDR_W-1:`SET_BITS+3];
    assign fillWay   = replWay[fillSet];
    assign storeSet  = storeAddr[`SET_BITS+2:3];

    // Tag compare on both ways.
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = validMem[w][lookupSet] && (tagMem[w][lookupSet] == lookupTag);
        end
    end

    assign hit     = |wayHit;
    assign hitWay  = wayHit[1];
    assign hitData = dataMem[hitWay][lookupSet];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < 2; w++) begin
                validMem[w] <= '0;
            end
            replWay <= '0;
        end else if (fillValid) begin
            validMem[fillWay][fillSet] <= 1'b1;
            replWay[fillSet] <= ~replWay[fillSet];    // Store hits leave this alone.
        end
    end

    // Line contents.
    always_ff @(posedge clk) begin
        if (fillValid) begin
            dataMem[fillWay][fillSet] <= fillData;
            tagMem[fillWay][fillSet]  <= fillTag;
        end
        if (storeValid) begin
            dataMem[storeWay][storeSet] <=
                mergeBytes(dataMem[storeWay][storeSet], storeData, storeMask);
        end
    end

endmodule

`default_nettype wire

/* cache/cacheController.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cacheController (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      reqValid,
    input  wire cachePkg::cpuReq_t   req,
    output logic                     busy,
    output logic                     respValid,
    output cachePkg::cpuResp_t       resp,
    output logic [`ADDR_W-1:0]       lookupAddr,
    input  wire                      hit,
    input  wire                      hitWay,
    input  wire [`DATA_W-1:0]        hitData,
    output logic                     fillValid,
    output logic [`ADDR_W-1:0]       fillAddr,
    output logic [`DATA_W-1:0]       fillData,
    output logic                     storeValid,
    output logic [`ADDR_W-1:0]       storeAddr,
    output logic                     storeWay,
    output logic [`DATA_W-1:0]       storeData,
    output logic [`MASK_W-1:0]       storeMask,
    output logic                     memReqValid,
    output cachePkg::memReq_t        memReq,
    input  wire                      memDone,
    input  wire [`DATA_W-1:0]        memRdata
);
    import cachePkg::*;

    ctrlState_t state;
    cpuReq_t    curReq;
    logic       acceptReq;

    assign acceptReq = (state == IDLE) && reqValid;    // Pulses while busy are dropped.
    assign busy      = (state != IDLE);
    assign respValid = (state == RESPOND);

    // Lookup only matters on the accept cycle.
    assign lookupAddr = req.addr;

    // Store hit merges at the request edge.
    assign storeValid = acceptReq && req.write && hit;
    assign storeAddr  = req.addr;
    assign storeWay   = hitWay;
    assign storeData  = req.data;
    assign storeMask  = req.mask;

    assign fillValid = (state == MEM_WAIT) && memDone && !curReq.write;
    assign fillAddr  = curReq.addr;
    assign fillData  = memRdata;

    always_comb begin
        memReq.cmd  = curReq.write ? MEM_WRITE : MEM_READ;
        memReq.addr = curReq.addr;
        memReq.data = curReq.data;
        memReq.mask = curReq.mask;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            memReqValid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (acceptReq) begin
                        if (!req.write && hit) begin
                            state <= RESPOND;
                        end else begin
                            state       <= MEM_WAIT;
                            memReqValid <= 1'b1;    // Held until memDone.
                        end
                    end
                end
                MEM_WAIT: begin
                    if (memDone) begin
                        state       <= RESPOND;
                        memReqValid <= 1'b0;
                    end
                end
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Request copy and response payload.
    always_ff @(posedge clk) begin
        if (acceptReq) begin
            curReq    <= req;
            resp.data <= req.write ? req.data : hitData;
            resp.hit  <= hit;
        end else if (fillValid) begin
            resp.data <= memRdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module memArbiter (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      reqValidA,
    input  wire cachePkg::memReq_t   reqA,
    input  wire                      reqValidB,
    input  wire cachePkg::memReq_t   reqB,
    output logic                     doneA,
    output logic                     doneB,
    output logic [`DATA_W-1:0]       rdata,
    output logic                     memStart,
    output cachePkg::memReq_t        memReq,
    input  wire                      memFinish,
    input  wire [`DATA_W-1:0]        memRdata
);

    logic active;        // Memory access in flight.
    logic owner;         // 0 is A, 1 is B.
    logic lastWinner;
    logic anyReq;
    logic grantB;
    logic newGrant;

    assign anyReq   = reqValidA || reqValidB;
    // B wins if alone, or if both ask and A had the last turn.
    assign grantB   = reqValidB && (!reqValidA || !lastWinner);
    assign newGrant = !active && anyReq;

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            memStart   <= 1'b0;
            owner      <= 1'b0;
            lastWinner <= 1'b1;    // A takes the first contest.
        end else begin
            memStart <= newGrant;
            if (newGrant) begin
                active     <= 1'b1;
                owner      <= grantB;
                lastWinner <= grantB;
            end else if (active && memFinish) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (newGrant) begin
            memReq <= grantB ? reqB : reqA;
        end
    end

    assign doneA = memFinish && active && !owner;
    assign doneB = memFinish && active && owner;
    assign rdata = memRdata;

endmodule

`default_nettype wire

/* verilog/backingMemory.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module backingMemory (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      memStart,
    input  wire cachePkg::memReq_t   memReq,
    output logic                     memFinish,
    output logic [`DATA_W-1:0]       memRdata
);
    import cachePkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [`DATA_W-1:0] mem [`MEM_WORDS];
    memReq_t            curReq;
    logic               active;
    logic [CNT_W-1:0]   count;
    logic [IDX_W-1:0]   wordIdx;

    assign wordIdx = curReq.addr[IDX_W+2:3];

    // Last cycle of the countdown.
    assign memFinish = active && (count == CNT_W'(1));
    assign memRdata  = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            count  <= '0;
        end else if (memStart) begin
            active <= 1'b1;
            count  <= CNT_W'(`MEM_LATENCY);
        end else if (active) begin
            count <= count - 1'b1;
            if (memFinish) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memStart) begin
            curReq <= memReq;
        end
        if (memFinish && curReq.cmd == MEM_WRITE) begin
            mem[wordIdx] <= mergeBytes(mem[wordIdx], curReq.data, curReq.mask);
        end
    end

endmodule

`default_nettype wire

/* verilog/dualCacheTop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module dualCacheTop (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      reqValidA,
    input  wire cachePkg::cpuReq_t   reqA,
    output logic                     busyA,
    output logic                     respValidA,
    output cachePkg::cpuResp_t       respA,
    input  wire                      reqValidB,
    input  wire cachePkg::cpuReq_t   reqB,
    output logic                     busyB,
    output logic                     respValidB,
    output cachePkg::cpuResp_t       respB
);
    import cachePkg::*;

    // Core side, index 0 is A.
    logic     coreReqValid [2];
    cpuReq_t  coreReq [2];
    logic     coreBusy [2];
    logic     coreRespValid [2];
    cpuResp_t coreResp [2];

    // Controller to arbiter.
    logic               memReqValid [2];
    memReq_t            memReqs [2];
    logic               memDone [2];
    logic [`DATA_W-1:0] memRdata;

    // Arbiter to memory.
    logic               memStart;
    memReq_t            memReq;
    logic               memFinish;
    logic [`DATA_W-1:0] memData;

    assign coreReqValid[0] = reqValidA;
    assign coreReq[0]      = reqA;
    assign coreReqValid[1] = reqValidB;
    assign coreReq[1]      = reqB;

    assign busyA      = coreBusy[0];
    assign respValidA = coreRespValid[0];
    assign respA      = coreResp[0];
    assign busyB      = coreBusy[1];
    assign respValidB = coreRespValid[1];
    assign respB      = coreResp[1];

    for (genvar c = 0; c < 2; c++) begin : gCore
        logic [`ADDR_W-1:0] lookupAddr;
        logic               hit;
        logic               hitWay;
        logic [`DATA_W-1:0] hitData;
        logic               fillValid;
        logic [`ADDR_W-1:0] fillAddr;
        logic [`DATA_W-1:0] fillData;
        logic               storeValid;
        logic [`ADDR_W-1:0] storeAddr;
        logic               storeWay;
        logic [`DATA_W-1:0] storeData;
        logic [`MASK_W-1:0] storeMask;

        cacheController ctrl (
            .clk(clk), .rst(rst),
            .reqValid(coreReqValid[c]), .req(coreReq[c]), .busy(coreBusy[c]),
            .respValid(coreRespValid[c]), .resp(coreResp[c]),
            .lookupAddr(lookupAddr), .hit(hit), .hitWay(hitWay), .hitData(hitData),
            .fillValid(fillValid), .fillAddr(fillAddr), .fillData(fillData),
            .storeValid(storeValid), .storeAddr(storeAddr), .storeWay(storeWay),
            .storeData(storeData), .storeMask(storeMask),
            .memReqValid(memReqValid[c]), .memReq(memReqs[c]),
            .memDone(memDone[c]), .memRdata(memRdata)
        );

        cacheArray cache (
            .clk(clk), .rst(rst),
            .lookupAddr(lookupAddr), .hit(hit), .hitWay(hitWay), .hitData(hitData),
            .fillValid(fillValid), .fillAddr(fillAddr), .fillData(fillData),
            .storeValid(storeValid), .storeAddr(storeAddr), .storeWay(storeWay),
            .storeData(storeData), .storeMask(storeMask)
        );
    end

    memArbiter arb (
        .clk(clk), .rst(rst),
        .reqValidA(memReqValid[0]), .reqA(memReqs[0]),
        .reqValidB(memReqValid[1]), .reqB(memReqs[1]),
        .doneA(memDone[0]), .doneB(memDone[1]), .rdata(memRdata),
        .memStart(memStart), .memReq(memReq),
        .memFinish(memFinish), .memRdata(memData)
    );

    backingMemory mem (
        .clk(clk), .rst(rst),
        .memStart(memStart), .memReq(memReq),
        .memFinish(memFinish), .memRdata(memData)
    );

endmodule

`default_nettype wire

/* sim/dualCacheTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module dualCacheTb;
    import cachePkg::*;

    localparam int NUM_SETS    = 1 << `SET_BITS;
    localparam int TAG_W       = `ADDR_W - `SET_BITS - 3;
    localparam int IDX_W       = $clog2(`MEM_WORDS);
    localparam int DRIVE_DELAY = 10;

    // Row modes.
    localparam logic [1:0] SOLO        = 2'd0;
    localparam logic [1:0] WITH_NEXT   = 2'd1;    // Issued in the same cycle as the next row.
    localparam logic [1:0] AFTER_RESET = 2'd2;

    localparam logic CORE_A = 1'b0;
    localparam logic CORE_B = 1'b1;

    typedef struct packed {
        logic               port;
        logic               write;
        logic [`ADDR_W-1:0] addr;
        logic [`MASK_W-1:0] mask;
        logic               randData;
        logic [`DATA_W-1:0] data;
        logic [1:0]         mode;
    } stimRow_t;

    logic     clk;
    logic     rst;
    logic     reqValidA;
    cpuReq_t  reqA;
    logic     busyA;
    logic     respValidA;
    cpuResp_t respA;
    logic     reqValidB;
    cpuReq_t  reqB;
    logic     busyB;
    logic     respValidB;
    cpuResp_t respB;

    stimRow_t stim [$];
    string    names [$];
    integer   seed;
    int       errorCount;
    int       testCount;
    int       passedCount;
    logic     timedOut;

    // Reference model indexed by core, way and set.
    logic [`DATA_W-1:0] refMem [`MEM_WORDS];
    logic [TAG_W-1:0]   refTag [2][2][NUM_SETS];
    logic [`DATA_W-1:0] refData [2][2][NUM_SETS];
    logic               refValid [2][2][NUM_SETS];
    logic               refToggle [2][NUM_SETS];

    dualCacheTop dut (
        .clk(clk), .rst(rst),
        .reqValidA(reqValidA), .reqA(reqA), .busyA(busyA),
        .respValidA(respValidA), .respA(respA),
        .reqValidB(reqValidB), .reqB(reqB), .busyB(busyB),
        .respValidB(respValidB), .respB(respB)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [`DATA_W-1:0] maskedUpdate(
        input logic [`DATA_W-1:0] oldWord,
        input logic [`DATA_W-1:0] newWord,
        input logic [`MASK_W-1:0] mask
    );
        logic [`DATA_W-1:0] laneMask;
        for (int i = 0; i < `MASK_W; i++) begin
            laneMask[8*i +: 8] = {8{mask[i]}};
        end
        return (oldWord & ~laneMask) | (newWord & laneMask);
    endfunction

    task automatic addRow(input string name, input logic port, input logic write,
                          input logic [`ADDR_W-1:0] addr, input logic [`MASK_W-1:0] mask,
                          input logic randData, input logic [`DATA_W-1:0] data,
                          input logic [1:0] mode);
        stimRow_t r;
        r.port     = port;
        r.write    = write;
        r.addr     = addr;
        r.mask     = mask;
        r.randData = randData;
        r.data     = data;
        r.mode     = mode;
        stim.push_back(r);
        names.push_back(name);
    endtask

    task automatic buildTable();
        addRow("store full miss", CORE_A, 1, 64'h010, 8'hFF, 1, '0, SOLO);
        addRow("load after store miss", CORE_A, 0, 64'h010, 8'h00, 0, '0, SOLO);
        addRow("repeat load hit", CORE_A, 0, 64'h010, 8'h00, 0, '0, SOLO);
        addRow("partial store hit", CORE_A, 1, 64'h010, 8'h0F, 1, '0, SOLO);
        addRow("load merged low", CORE_A, 0, 64'h010, 8'h00, 0, '0, SOLO);
        addRow("odd lane store hit", CORE_A, 1, 64'h010, 8'hA5, 0,
               64'h1122_3344_5566_7788, SOLO);
        addRow("load merged lanes", CORE_A, 0, 64'h010, 8'h00, 0, '0, SOLO);
        // Three tags in set 1.
        addRow("set1 store tag 0", CORE_A, 1, 64'h008, 8'hFF, 1, '0, SOLO);
        addRow("set1 store tag 1", CORE_A, 1, 64'h028, 8'hFF, 1, '0, SOLO);
        addRow("set1 store tag 2", CORE_A, 1, 64'h048, 8'hFF, 1, '0, SOLO);
        addRow("set1 load tag 0", CORE_A, 0, 64'h008, 8'h00, 0, '0, SOLO);
        addRow("set1 load tag 1", CORE_A, 0, 64'h028, 8'h00, 0, '0, SOLO);
        addRow("set1 load tag 2 evict", CORE_A, 0, 64'h048, 8'h00, 0, '0, SOLO);
        addRow("set1 tag 1 still hit", CORE_A, 0, 64'h028, 8'h00, 0, '0, SOLO);
        addRow("set1 tag 0 reload", CORE_A, 0, 64'h008, 8'h00, 0, '0, SOLO);
        // Both cores at once. A stays below 0x400 and B above.
        addRow("pair A store", CORE_A, 1, 64'h0C0, 8'hFF, 1, '0, WITH_NEXT);
        addRow("pair B store", CORE_B, 1, 64'h4C0, 8'hFF, 1, '0, SOLO);
        addRow("pair A load miss", CORE_A, 0, 64'h0C0, 8'h00, 0, '0, WITH_NEXT);
        addRow("pair B load miss", CORE_B, 0, 64'h4C0, 8'h00, 0, '0, SOLO);
        addRow("pair A load hit", CORE_A, 0, 64'h0C0, 8'h00, 0, '0, WITH_NEXT);
        addRow("pair B load hit", CORE_B, 0, 64'h4C0, 8'h00, 0, '0, SOLO);
        addRow("pair A partial store", CORE_A, 1, 64'h0C0, 8'hF0, 1, '0, WITH_NEXT);
        addRow("pair B partial store", CORE_B, 1, 64'h4C0, 8'h3C, 1, '0, SOLO);
        addRow("pair A store new", CORE_A, 1, 64'h0E0, 8'hFF, 1, '0, WITH_NEXT);
        addRow("pair B load merged", CORE_B, 0, 64'h4C0, 8'h00, 0, '0, SOLO);
        addRow("pair B store new", CORE_B, 1, 64'h4E0, 8'hFF, 1, '0, WITH_NEXT);
        addRow("pair A load new", CORE_A, 0, 64'h0E0, 8'h00, 0, '0, SOLO);
        addRow("pair A load merged", CORE_A, 0, 64'h0C0, 8'h00, 0, '0, WITH_NEXT);
        addRow("pair B load new", CORE_B, 0, 64'h4E0, 8'h00, 0, '0, SOLO);
        addRow("reset A load miss", CORE_A, 0, 64'h010, 8'h00, 0, '0, AFTER_RESET);
        addRow("reset B load miss", CORE_B, 0, 64'h4C0, 8'h00, 0, '0, SOLO);
        addRow("reset A load hit", CORE_A, 0, 64'h010, 8'h00, 0, '0, SOLO);
    endtask

    task automatic clearModel();
        for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                refToggle[c][s] = 1'b0;
                for (int w = 0; w < 2; w++) begin
                    refValid[c][w][s] = 1'b0;
                end
            end
        end
    endtask

    // Expected response, and the model update for one request.
    task automatic predict(input stimRow_t r, input logic [`DATA_W-1:0] wdata,
                           output logic [`DATA_W-1:0] expData, output logic expHit);
        logic                 c;
        logic [`SET_BITS-1:0] s;
        logic [TAG_W-1:0]     tag;
        logic [IDX_W-1:0]     idx;
        logic                 way;
        c      = r.port;
        s      = r.addr[`SET_BITS+2:3];
        tag    = r.addr[`ADDR_W-1:`SET_BITS+3];
        idx    = r.addr[IDX_W+2:3];
        expHit = 1'b0;
        way    = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (refValid[c][w][s] && refTag[c][w][s] == tag) begin
                expHit = 1'b1;
                way    = w[0];
            end
        end
        if (r.write) begin
            expData = wdata;    // Stores echo their data.
            if (expHit) begin
                refData[c][way][s] = maskedUpdate(refData[c][way][s], wdata, r.mask);
            end
            refMem[idx] = maskedUpdate(refMem[idx], wdata, r.mask);
        end else if (expHit) begin
            expData = refData[c][way][s];
        end else begin
            expData = refMem[idx];
            way = refToggle[c][s];
            refTag[c][way][s]   = tag;
            refData[c][way][s]  = expData;
            refValid[c][way][s] = 1'b1;
            refToggle[c][s]     = ~refToggle[c][s];
        end
    endtask

    task automatic compareData(input string name, input logic [`DATA_W-1:0] expected,
                               input logic [`DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s data expected %h actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic compareHit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s hit expected %b actual %b", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic compareBusy(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s busy expected %b actual %b", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
    endtask

    task automatic waitIdle(output logic ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < `TIMEOUT_CYCLES) begin
            @(negedge clk);
            ok = !busyA && !busyB;
            cycles++;
        end
        if (!ok) begin
            $display("Timeout: a core stayed busy for %0d cycles", `TIMEOUT_CYCLES);
            timedOut = 1'b1;
        end
    endtask

    task automatic waitResponses(input logic needA, input logic needB,
                                 output cpuResp_t gotA, output cpuResp_t gotB,
                                 output logic heldA, output logic heldB,
                                 output logic ok);
        logic seenA;
        logic seenB;
        int   cycles;
        seenA  = !needA;
        seenB  = !needB;
        gotA   = '0;
        gotB   = '0;
        heldA  = 1'b1;
        heldB  = 1'b1;
        cycles = 0;
        while (!(seenA && seenB) && cycles < `TIMEOUT_CYCLES) begin
            @(negedge clk);
            // A pending request keeps busy high until its response.
            if (!seenA && !respValidA && !busyA) begin
                heldA = 1'b0;
            end
            if (!seenB && !respValidB && !busyB) begin
                heldB = 1'b0;
            end
            if (respValidA && !seenA) begin
                gotA  = respA;
                seenA = 1'b1;
            end
            if (respValidB && !seenB) begin
                gotB  = respB;
                seenB = 1'b1;
            end
            cycles++;
        end
        ok = seenA && seenB;
        if (!ok) begin
            $display("Timeout: no response from core %s within %0d cycles",
                     seenA ? "B" : "A", `TIMEOUT_CYCLES);
            timedOut = 1'b1;
        end
    endtask

    task automatic driveRequest(input stimRow_t r, input logic [`DATA_W-1:0] wdata);
        cpuReq_t req;
        req.write = r.write;
        req.addr  = r.addr;
        req.data  = wdata;
        req.mask  = r.mask;
        if (r.port == CORE_B) begin
            reqB      = req;
            reqValidB = 1'b1;
        end else begin
            reqA      = req;
            reqValidA = 1'b1;
        end
    endtask

    // One row, or two rows issued in the same cycle.
    task automatic runGroup(input int first, input int count);
        logic [`DATA_W-1:0] wdata [2];
        logic [`DATA_W-1:0] expData [2];
        logic               expHit [2];
        cpuResp_t           gotA;
        cpuResp_t           gotB;
        cpuResp_t           got;
        logic               heldA;
        logic               heldB;
        logic               held;
        logic               ok;
        logic               needA;
        logic               needB;
        int                 errorsBefore;
        stimRow_t           r;
        waitIdle(ok);
        if (!ok) return;
        needA = 1'b0;
        needB = 1'b0;
        for (int k = 0; k < count; k++) begin
            r = stim[first + k];
            if (r.randData) begin
                wdata[k] = {$random(seed), $random(seed)};
            end else begin
                wdata[k] = r.data;
            end
            predict(r, wdata[k], expData[k], expHit[k]);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        for (int k = 0; k < count; k++) begin
            driveRequest(stim[first + k], wdata[k]);
            if (stim[first + k].port == CORE_B) needB = 1'b1;
            else needA = 1'b1;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        reqValidA = 1'b0;
        reqValidB = 1'b0;
        waitResponses(needA, needB, gotA, gotB, heldA, heldB, ok);
        if (!ok) return;
        for (int k = 0; k < count; k++) begin
            got  = (stim[first + k].port == CORE_B) ? gotB : gotA;
            held = (stim[first + k].port == CORE_B) ? heldB : heldA;
            errorsBefore = errorCount;
            compareData(names[first + k], expData[k], got.data);
            compareHit(names[first + k], expHit[k], got.hit);
            compareBusy(names[first + k], 1'b1, held);
            testCount++;
            if (errorCount == errorsBefore) begin
                passedCount++;
                $display("[%0d] %s: ok", first + k, names[first + k]);
            end else begin
                $display("[%0d] %s: mismatch", first + k, names[first + k]);
            end
        end
    endtask

    initial begin
        int i;
        int count;
        rst         = 1'b1;
        reqValidA   = 1'b0;
        reqValidB   = 1'b0;
        reqA        = '0;
        reqB        = '0;
        seed        = 30;
        errorCount  = 0;
        testCount   = 0;
        passedCount = 0;
        timedOut    = 1'b0;
        buildTable();
        clearModel();
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        i = 0;
        while (i < stim.size() && !timedOut) begin
            if (stim[i].mode == AFTER_RESET) begin
                applyReset();
                clearModel();    // Memory keeps its words.
            end
            count = (stim[i].mode == WITH_NEXT) ? 2 : 1;
            runGroup(i, count);
            i += count;
        end

        $display("Tests: %0d run, %0d passed, %0d failed, %0d errors", testCount,
                 passedCount, testCount - passedCount, errorCount);
        if (errorCount == 0 && !timedOut && testCount == stim.size()) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* l1Cache.f */
+incdir+common
common/cachePkg.sv
cache/cacheArray.sv
cache/cacheController.sv
verilog/memArbiter.sv
verilog/backingMemory.sv
verilog/dualCacheTop.sv
sim/dualCacheTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dualCacheTb
FILELIST  ?= l1Cache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
